// File: ntm_arithmetic_pkg.sv
package ntm_arithmetic_pkg;

  ////////////////////
  // Float word types
  ////////////////////

  // One IEEE-754 double as raw bits
  typedef logic [63:0] float_word_t;

  // Biased exponent field of a double
  typedef logic [10:0] exponent_t;

  // Reset value of data registers
  localparam float_word_t ZERO_DATA = '0;

  // Exponent of infinity and NaN
  localparam exponent_t EXPONENT_ALL_ONES = '1;

  // Exponent field position inside the word
  localparam int EXPONENT_MSB = 62;
  localparam int EXPONENT_LSB = 52;

endpackage

// File: ntm_scalar_if.sv
`timescale 1ns/10ps

interface ntm_scalar_if #(
  parameter int CONTROL_SIZE = 8
) ();

  import ntm_arithmetic_pkg::*;

  // Issue side, one pair per start pulse
  logic                    start;
  logic                    operation;
  float_word_t             data_a;
  float_word_t             data_b;
  logic [CONTROL_SIZE-1:0] size;

  // Result side, one pulse per pair
  logic        ready;
  float_word_t data_out;
  logic        overflow;

  modport loader (output start, operation, data_a, data_b, size, input ready);

  modport adder (input start, operation, data_a, data_b, output ready, data_out, overflow);

  // Collector also needs the latched vector length
  modport collector (input size, ready, data_out, overflow);

endinterface

// File: ntm_vector_loader.sv
`timescale 1ns/10ps

module ntm_vector_loader #(
  parameter int CONTROL_SIZE = 8
) (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           START,
  input  logic                           OPERATION,
  input  logic [CONTROL_SIZE-1:0]        SIZE_IN,
  input  ntm_arithmetic_pkg::float_word_t DATA_A_IN,
  input  logic                           DATA_A_IN_ENABLE,
  input  ntm_arithmetic_pkg::float_word_t DATA_B_IN,
  input  logic                           DATA_B_IN_ENABLE,
  ntm_scalar_if.loader                   scalar
);

  ////////////////////
  // Types and signals
  ////////////////////

  // Element counter width follows the length port
  typedef logic [CONTROL_SIZE-1:0] count_t;

  typedef enum logic [1:0] {
    IDLE,
    COLLECT,
    ISSUE
  } loader_state_t;

  loader_state_t state;

  // One flag per operand, so A and B may come in any order
  logic a_full;
  logic b_full;

  // Pairs handed to the adder in this vector
  count_t issued_count;

  ////////////////////
  // Operand holding
  ////////////////////

  // Interface data lines double as the operand registers
  always_ff @(posedge CLK) begin
    if (DATA_A_IN_ENABLE) begin
      scalar.data_a <= DATA_A_IN;
    end
    if (DATA_B_IN_ENABLE) begin
      scalar.data_b <= DATA_B_IN;
    end
  end

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state            <= IDLE;
      scalar.start     <= 1'b0;
      scalar.operation <= 1'b0;
      scalar.size      <= '0;
      issued_count     <= '0;
      a_full           <= 1'b0;
      b_full           <= 1'b0;
    end else begin
      // Start is a single cycle pulse
      scalar.start <= 1'b0;

      // Operand arrival, in any state
      if (DATA_A_IN_ENABLE) begin
        a_full <= 1'b1;
      end
      if (DATA_B_IN_ENABLE) begin
        b_full <= 1'b1;
      end

      case (state)
        IDLE: begin
          // Vector length and operation fixed for the whole vector
          if (START) begin
            scalar.size      <= SIZE_IN;
            scalar.operation <= OPERATION;
            issued_count     <= '0;
            state            <= COLLECT;
          end
        end
        COLLECT: begin
          // Nothing outstanding here, so a full pair goes out at once
          if (a_full && b_full) begin
            scalar.start <= 1'b1;
            a_full       <= 1'b0;
            b_full       <= 1'b0;
            issued_count <= issued_count + 1'b1;
            state        <= ISSUE;
          end
        end
        ISSUE: begin
          // Pair outstanding until the adder answers
          if (scalar.ready) begin
            state <= (issued_count == scalar.size) ? IDLE : COLLECT;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // An operand is never overwritten before its pair has gone out
  a_not_overrun : assert property (@(posedge CLK) disable iff (RST)
    DATA_A_IN_ENABLE |-> !a_full);
  b_not_overrun : assert property (@(posedge CLK) disable iff (RST)
    DATA_B_IN_ENABLE |-> !b_full);

endmodule

// File: ntm_scalar_float_adder.sv
`timescale 1ns/10ps

module ntm_scalar_float_adder (
  input logic         CLK,
  input logic         RST,
  ntm_scalar_if.adder scalar
);

  import ntm_arithmetic_pkg::*;

  ////////////////////
  // Types and signals
  ////////////////////

  typedef enum logic {
    STARTER,
    ENDER
  } adder_state_t;

  adder_state_t state;

  // Operands as reals for the arithmetic step
  real data_a_int;
  real data_b_int;

  // Operand exponents kept for the overflow rule
  exponent_t exponent_a;
  exponent_t exponent_b;

  // Raw sum or difference, then its registered copy
  float_word_t sum_bits;
  float_word_t result_int;
  logic        overflow_int;
  logic        done_int;

  // Add, or subtract when operation is high
  always_comb begin
    if (scalar.operation) begin
      sum_bits = $realtobits(data_a_int - data_b_int);
    end else begin
      sum_bits = $realtobits(data_a_int + data_b_int);
    end
  end

  ////////////////////
  // Engine
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= STARTER;
      done_int <= 1'b0;
    end else begin
      case (state)
        STARTER: begin
          done_int <= 1'b0;
          if (scalar.start) begin
            state <= ENDER;
          end
        end
        ENDER: begin
          done_int <= 1'b1;
          state    <= STARTER;
        end
        default: begin
          state <= STARTER;
        end
      endcase
    end
  end

  // Operand capture and result step
  always_ff @(posedge CLK) begin
    if (state == STARTER && scalar.start) begin
      data_a_int <= $bitstoreal(scalar.data_a);
      data_b_int <= $bitstoreal(scalar.data_b);
      exponent_a <= scalar.data_a[EXPONENT_MSB:EXPONENT_LSB];
      exponent_b <= scalar.data_b[EXPONENT_MSB:EXPONENT_LSB];
    end
    if (state == ENDER) begin
      result_int <= sum_bits;
      // Infinity produced here, not carried in from an operand
      overflow_int <= (sum_bits[EXPONENT_MSB:EXPONENT_LSB] == EXPONENT_ALL_ONES) &&
                      (exponent_a != EXPONENT_ALL_ONES) &&
                      (exponent_b != EXPONENT_ALL_ONES);
    end
  end

  // Output register, result valid with the ready pulse
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      scalar.ready    <= 1'b0;
      scalar.data_out <= ZERO_DATA;
      scalar.overflow <= 1'b0;
    end else begin
      scalar.ready <= done_int;
      if (done_int) begin
        scalar.data_out <= result_int;
        scalar.overflow <= overflow_int;
      end
    end
  end

  // Loader holds off while a pair is in flight
  no_start_in_ender : assert property (@(posedge CLK) disable iff (RST)
    state == ENDER |-> !scalar.start);

  // Fixed latency from start to ready
  ready_after_start : assert property (@(posedge CLK) disable iff (RST)
    scalar.start |-> ##3 scalar.ready);

endmodule

// File: ntm_vector_collector.sv
`timescale 1ns/10ps

module ntm_vector_collector #(
  parameter int CONTROL_SIZE = 8
) (
  input  logic                            CLK,
  input  logic                            RST,
  ntm_scalar_if.collector                 scalar,
  output ntm_arithmetic_pkg::float_word_t DATA_OUT,
  output logic                            DATA_OUT_ENABLE,
  output logic                            OVERFLOW_OUT,
  output logic                            READY
);

  import ntm_arithmetic_pkg::*;

  ////////////////////
  // Types and signals
  ////////////////////

  // Element counter width follows the length
  typedef logic [CONTROL_SIZE-1:0] count_t;

  // Results already passed out in this vector
  count_t done_count;
  count_t count_next;

  assign count_next = done_count + 1'b1;

  ////////////////////
  // Result path
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT        <= ZERO_DATA;
      DATA_OUT_ENABLE <= 1'b0;
      OVERFLOW_OUT    <= 1'b0;
      READY           <= 1'b0;
      done_count      <= '0;
    end else begin
      // One enable per adder result, no back-pressure
      DATA_OUT_ENABLE <= scalar.ready;
      READY           <= 1'b0;

      if (scalar.ready) begin
        DATA_OUT <= scalar.data_out;

        // First result of a vector drops the old sticky flag
        if (done_count == '0) begin
          OVERFLOW_OUT <= scalar.overflow;
        end else begin
          OVERFLOW_OUT <= OVERFLOW_OUT | scalar.overflow;
        end

        // Last element closes the vector
        if (count_next == scalar.size) begin
          READY      <= 1'b1;
          done_count <= '0;
        end else begin
          done_count <= count_next;
        end
      end
    end
  end

  // End of vector only comes with a result
  ready_with_data : assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE);

endmodule

// File: ntm_vector_float_adder.sv
`timescale 1ns/10ps

module ntm_vector_float_adder #(
  parameter int CONTROL_SIZE = 8
) (
  input  logic                            CLK,
  input  logic                            RST,

  // Vector control
  input  logic                            START,
  output logic                            READY,
  input  logic                            OPERATION,
  input  logic [CONTROL_SIZE-1:0]         SIZE_IN,

  // Element streams in
  input  ntm_arithmetic_pkg::float_word_t DATA_A_IN,
  input  logic                            DATA_A_IN_ENABLE,
  input  ntm_arithmetic_pkg::float_word_t DATA_B_IN,
  input  logic                            DATA_B_IN_ENABLE,

  // Result stream out
  output ntm_arithmetic_pkg::float_word_t DATA_OUT,
  output logic                            DATA_OUT_ENABLE,
  output logic                            OVERFLOW_OUT
);

  // Pair and result link between the three stages
  ntm_scalar_if #(.CONTROL_SIZE(CONTROL_SIZE)) scalar_bus ();

  // Input side
  ntm_vector_loader #(.CONTROL_SIZE(CONTROL_SIZE)) loader_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .OPERATION        (OPERATION),
    .SIZE_IN          (SIZE_IN),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .scalar           (scalar_bus.loader)
  );

  // Scalar add and subtract
  ntm_scalar_float_adder adder_i (
    .CLK    (CLK),
    .RST    (RST),
    .scalar (scalar_bus.adder)
  );

  // Output side
  ntm_vector_collector #(.CONTROL_SIZE(CONTROL_SIZE)) collector_i (
    .CLK             (CLK),
    .RST             (RST),
    .scalar          (scalar_bus.collector),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .OVERFLOW_OUT    (OVERFLOW_OUT),
    .READY           (READY)
  );

endmodule

// File: ntm_vector_float_adder_tb.sv
`timescale 1ns/10ps

module ntm_vector_float_adder_tb;

  import ntm_arithmetic_pkg::*;

  localparam int CONTROL_SIZE = 8;
  // Elements over all vectors of the run
  localparam int ELEMENTS_SENT = 20;
  localparam int VECTORS_SENT = 5;
  localparam int CYCLE_LIMIT = 200 * ELEMENTS_SENT + 1000;

  logic                    CLK;
  logic                    RST;
  logic                    START;
  logic                    OPERATION;
  logic [CONTROL_SIZE-1:0] SIZE_IN;
  float_word_t             DATA_A_IN;
  logic                    DATA_A_IN_ENABLE;
  float_word_t             DATA_B_IN;
  logic                    DATA_B_IN_ENABLE;
  float_word_t             DATA_OUT;
  logic                    DATA_OUT_ENABLE;
  logic                    OVERFLOW_OUT;
  logic                    READY;

  // Expected results in issue order, overflow already made sticky
  float_word_t exp_data_q[$];
  logic        exp_ovf_q[$];
  // Last element flag and vector name travel with each result
  logic        exp_last_q[$];
  string       exp_name_q[$];

  // Operands of the vector under test
  real vec_a [0:7];
  real vec_b [0:7];

  string test_name = "none";
  int    error_count = 0;
  int    results_seen = 0;
  int    ready_count = 0;
  int    cycle_count = 0;

  ntm_vector_float_adder #(.CONTROL_SIZE(CONTROL_SIZE)) dut_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .READY            (READY),
    .OPERATION        (OPERATION),
    .SIZE_IN          (SIZE_IN),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_OUT         (DATA_OUT),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .OVERFLOW_OUT     (OVERFLOW_OUT)
  );

  always #5 CLK = ~CLK;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic report_mismatch(input string name, input string what,
                                 input logic [63:0] exp_val, input logic [63:0] act_val);
    error_count++;
    $display("** Error %s: %s expected %h, actual %h", name, what, exp_val, act_val);
  endtask

  // Overflow rule: infinite result from finite operands
  function automatic logic overflow_expected(input real a, input real b, input real r);
    logic [63:0] a_bits;
    logic [63:0] b_bits;
    logic [63:0] r_bits;
    a_bits = $realtobits(a);
    b_bits = $realtobits(b);
    r_bits = $realtobits(r);
    return (r_bits[62:52] == 11'h7ff) && (a_bits[62:52] != 11'h7ff) &&
           (b_bits[62:52] != 11'h7ff);
  endfunction

  // Roughly +-1000 with a fraction
  function automatic real random_operand();
    return (real'($urandom % 2000001) - 1000000.0) / 1024.0;
  endfunction

  task automatic strobe_a(input real a);
    DATA_A_IN        = $realtobits(a);
    DATA_A_IN_ENABLE = 1'b1;
    @(negedge CLK);
    DATA_A_IN_ENABLE = 1'b0;
  endtask

  task automatic strobe_b(input real b);
    DATA_B_IN        = $realtobits(b);
    DATA_B_IN_ENABLE = 1'b1;
    @(negedge CLK);
    DATA_B_IN_ENABLE = 1'b0;
  endtask

  // Zero gap sends both operands in one cycle
  task automatic send_pair(input real a, input real b, input logic b_first, input int max_gap);
    if (max_gap == 0) begin
      DATA_A_IN        = $realtobits(a);
      DATA_B_IN        = $realtobits(b);
      DATA_A_IN_ENABLE = 1'b1;
      DATA_B_IN_ENABLE = 1'b1;
      @(negedge CLK);
      DATA_A_IN_ENABLE = 1'b0;
      DATA_B_IN_ENABLE = 1'b0;
    end else if (b_first) begin
      strobe_b(b);
      repeat ($urandom_range(max_gap, 0)) @(negedge CLK);
      strobe_a(a);
    end else begin
      strobe_a(a);
      repeat ($urandom_range(max_gap, 0)) @(negedge CLK);
      strobe_b(b);
    end
  endtask

  task automatic run_vector(input string name, input logic op, input int len,
                            input logic b_first, input int max_gap);
    logic sticky;
    real  r;
    test_name        = name;
    sticky           = 1'b0;
    START            = 1'b1;
    SIZE_IN          = len[CONTROL_SIZE-1:0];
    OPERATION        = op;
    @(negedge CLK);
    START = 1'b0;
    for (int i = 0; i < len; i++) begin
      r      = op ? vec_a[i] - vec_b[i] : vec_a[i] + vec_b[i];
      sticky = sticky | overflow_expected(vec_a[i], vec_b[i], r);
      exp_data_q.push_back($realtobits(r));
      exp_ovf_q.push_back(sticky);
      exp_last_q.push_back(i == len - 1);
      exp_name_q.push_back(name);
      send_pair(vec_a[i], vec_b[i], b_first, max_gap);
      // No back-pressure, next element only after this result
      while (!DATA_OUT_ENABLE) @(negedge CLK);
    end
    assert (READY) else begin
      error_count++;
      $display("READY did not pulse with the last result of %s", name);
    end
  endtask

  ////////////////////
  // Result checking
  ////////////////////

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge CLK) begin : check_results
    float_word_t exp_data;
    logic        exp_ovf;
    logic        exp_last;
    string       exp_name;
    if (!RST && (DATA_OUT_ENABLE || READY)) begin
      results_seen++;
      if (exp_data_q.size() == 0) begin
        error_count++;
        $display("Result in %s arrived with no element outstanding", test_name);
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_ovf  = exp_ovf_q.pop_front();
        exp_last = exp_last_q.pop_front();
        exp_name = exp_name_q.pop_front();
        assert (DATA_OUT_ENABLE)
          else report_mismatch(exp_name, "DATA_OUT_ENABLE", 64'd1, 64'd0);
        assert (DATA_OUT === exp_data)
          else report_mismatch(exp_name, "DATA_OUT", exp_data, DATA_OUT);
        assert (OVERFLOW_OUT === exp_ovf)
          else report_mismatch(exp_name, "OVERFLOW_OUT", 64'(exp_ovf), 64'(OVERFLOW_OUT));
        // READY exactly on element number SIZE_IN
        assert (READY === exp_last)
          else report_mismatch(exp_name, "READY", 64'(exp_last), 64'(READY));
      end
      if (READY) begin
        ready_count++;
      end
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not complete in %0d cycles, errors %0d", CYCLE_LIMIT,
               error_count);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    void'($urandom(32'h9948));
    CLK              = 1'b0;
    RST              = 1'b1;
    START            = 1'b0;
    OPERATION        = 1'b0;
    SIZE_IN          = '0;
    DATA_A_IN        = '0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN        = '0;
    DATA_B_IN_ENABLE = 1'b0;
    repeat (4) @(negedge CLK);

    // Reset values
    test_name = "reset";
    assert (READY === 1'b0) else report_mismatch(test_name, "READY", 64'd0, 64'(READY));
    assert (DATA_OUT_ENABLE === 1'b0)
      else report_mismatch(test_name, "DATA_OUT_ENABLE", 64'd0, 64'(DATA_OUT_ENABLE));
    assert (OVERFLOW_OUT === 1'b0)
      else report_mismatch(test_name, "OVERFLOW_OUT", 64'd0, 64'(OVERFLOW_OUT));
    assert (DATA_OUT === 64'd0) else report_mismatch(test_name, "DATA_OUT", 64'd0, DATA_OUT);
    RST = 1'b0;
    repeat (2) @(negedge CLK);

    for (int i = 0; i < 8; i++) begin
      vec_a[i] = random_operand();
      vec_b[i] = random_operand();
    end
    run_vector("add_random", 1'b0, 4, 1'b0, 0);
    run_vector("subtract_b_first", 1'b1, 5, 1'b1, 3);

    // Middle element overflows to infinity
    vec_a[0] = 1.0;
    vec_b[0] = 2.0;
    vec_a[1] = 1.7e308;
    vec_b[1] = 1.7e308;
    vec_a[2] = 3.5;
    vec_b[2] = -1.25;
    run_vector("overflow", 1'b0, 3, 1'b0, 1);
    repeat (3) @(negedge CLK);
    assert (OVERFLOW_OUT === 1'b1)
      else report_mismatch(test_name, "OVERFLOW_OUT", 64'd1, 64'(OVERFLOW_OUT));

    // Back to back, first result also clears the sticky flag
    for (int i = 0; i < 8; i++) begin
      vec_a[i] = random_operand();
      vec_b[i] = random_operand();
    end
    run_vector("back_to_back_long", 1'b0, 6, 1'b0, 2);
    run_vector("back_to_back_short", 1'b1, 2, 1'b0, 0);

    repeat (10) @(negedge CLK);
    assert (exp_data_q.size() == 0) else begin
      error_count++;
      $display("%0d expected results never arrived", exp_data_q.size());
    end
    assert (ready_count == VECTORS_SENT) else begin
      error_count++;
      $display("Saw %0d READY pulses for %0d vectors", ready_count, VECTORS_SENT);
    end
    $display("Errors %0d, results %0d, vectors %0d", error_count, results_seen, ready_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: project.f
ntm_arithmetic_pkg.sv
ntm_scalar_if.sv
ntm_vector_loader.sv
ntm_scalar_float_adder.sv
ntm_vector_collector.sv
ntm_vector_float_adder.sv
ntm_vector_float_adder_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  --top-module ntm_vector_float_adder_tb \
  -f project.f -o ntm_sim &&
./obj_dir/ntm_sim | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null &&
echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed"; exit 1; }
